// File: hw/icache_pkg.sv
package icache_pkg;

    localparam int ADDR_W = 32; // fetch byte address
    localparam int DATA_W = 32; // one instruction word
    localparam int ID_W   = 4;  // requester tag, echoed back

    // status carried with every response
    typedef enum logic [1:0] {
        RESP_OK       = 2'd0,
        RESP_MISALIGN = 2'd1, // low two address bits set, no lookup
        RESP_BUS_ERR  = 2'd2  // refill saw pslverr, data is zero
    } resp_status_e;

    // controller states, also steer the ram address mux
    typedef enum logic [1:0] {
        ST_RUN    = 2'd0, // normal lookups
        ST_REFILL = 2'd1, // line fetch over apb
        ST_RETRY  = 2'd2, // re-read rams for the stalled fetch
        ST_FLUSH  = 2'd3  // drop every valid bit
    } ctrl_state_e;

endpackage

// File: hw/apb_pkg.sv
package apb_pkg;

    localparam int APB_AW = 32;
    localparam int APB_DW = 32;

    // master side transfer phase
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_SETUP  = 2'd1, // psel high, penable low
        PH_ACCESS = 2'd2  // psel and penable high until pready
    } apb_phase_e;

endpackage

// File: hw/cmd_fifo.sv
module cmd_fifo import icache_pkg::*; #(
    parameter int DEPTH = 2
) (
    input  logic              clk_i,
    input  logic              srst_i,
    input  logic              push_i,
    input  logic [ID_W-1:0]   id_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              pop_i,
    output logic [ID_W-1:0]   id_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic              empty_o,
    output logic              full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ID_W-1:0]   id_mem   [DEPTH];
    logic [ADDR_W-1:0] addr_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;  // entries held

    // pointer step, wraps at depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            id_mem[wr_ptr]   <= id_i;
            addr_mem[wr_ptr] <= addr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (srst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_i) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    assign id_o    = id_mem[rd_ptr];   // head seen without a read cycle
    assign addr_o  = addr_mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // requester and fsm must both respect the flags
    a_no_overflow: assert property (@(posedge clk_i) disable iff (srst_i)
        !(push_i && full_o));
    a_no_underflow: assert property (@(posedge clk_i) disable iff (srst_i)
        !(pop_i && empty_o));

endmodule

// File: hw/tag_store.sv
module tag_store import icache_pkg::*; #(
    parameter int INDEX_W    = 4,
    parameter int WORD_OFS_W = 2,
    localparam int TAG_W     = ADDR_W - INDEX_W - WORD_OFS_W - 2
) (
    input  logic               clk_i,
    input  logic               srst_i,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  logic [TAG_W-1:0]   lv2_tag_i,
    output logic               hit_o,
    input  logic               wr_en_i,
    input  logic [INDEX_W-1:0] wr_index_i,
    input  logic [TAG_W-1:0]   wr_tag_i,
    input  logic               flush_clear_i
);

    localparam int LINES = 1 << INDEX_W;

    logic [TAG_W-1:0] tags [LINES];
    logic [LINES-1:0] valid_q;    // one bit per line
    logic [TAG_W-1:0] rd_tag_q;
    logic             rd_valid_q;

    // tag array, registered read like the data ram
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tags[wr_index_i] <= wr_tag_i;
        end
        rd_tag_q <= tags[rd_index_i];
    end

    always_ff @(posedge clk_i) begin
        if (srst_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_index_i] & ~flush_clear_i;
            if (flush_clear_i) begin
                valid_q <= '0;              // whole cache in one cycle
            end else if (wr_en_i) begin
                valid_q[wr_index_i] <= 1'b1; // line complete and clean
            end
        end
    end

    // compare against the fetch now sitting in level 2
    assign hit_o = rd_valid_q & (rd_tag_q == lv2_tag_i);

endmodule

// File: hw/data_ram.sv
module data_ram import icache_pkg::*; #(
    parameter int INDEX_W    = 4,
    parameter int WORD_OFS_W = 2
) (
    input  logic                          clk_i,
    input  logic [INDEX_W+WORD_OFS_W-1:0] addr_i,  // {line, word}
    input  logic                          we_i,
    input  logic [DATA_W-1:0]             wdata_i,
    output logic [DATA_W-1:0]             rdata_o
);

    localparam int DEPTH = 1 << (INDEX_W + WORD_OFS_W);

    logic [DATA_W-1:0] mem [DEPTH];

    // single port, word wide
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i; // refill beat
        end
        rdata_o <= mem[addr_i];     // one cycle read
    end

endmodule

// File: hw/refill_counter.sv
module refill_counter #(
    parameter int WORD_OFS_W = 2
) (
    input  logic                  clk_i,
    input  logic                  srst_i,
    input  logic                  busy_i,       // fsm in refill
    input  logic                  beat_done_i,
    output logic [WORD_OFS_W-1:0] beat_idx_o,
    output logic                  last_beat_o
);

    logic [WORD_OFS_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (srst_i || !busy_i) begin
            cnt_q <= '0;              // restart at word 0 for the next line
        end else if (beat_done_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign beat_idx_o  = cnt_q;
    assign last_beat_o = &cnt_q;      // final word of the line

    // the fsm leaves refill on the last beat, so the count never laps a line
    a_no_wrap: assert property (@(posedge clk_i) disable iff (srst_i)
        busy_i && beat_done_i && last_beat_o |=> !busy_i);

endmodule

// File: hw/apb_refill_master.sv
module apb_refill_master import apb_pkg::*; (
    input  logic              clk_i,
    input  logic              srst_i,
    input  logic              start_i,    // level, one transfer per idle phase
    input  logic [APB_AW-1:0] addr_i,
    output logic              psel_o,
    output logic              penable_o,
    output logic [APB_AW-1:0] paddr_o,
    input  logic              pready_i,
    input  logic [APB_DW-1:0] prdata_i,
    input  logic              pslverr_i,
    output logic              beat_done_o,
    output logic              beat_err_o,
    output logic [APB_DW-1:0] beat_data_o
);

    apb_phase_e phase_q;

    always_ff @(posedge clk_i) begin
        if (srst_i) begin
            phase_q <= PH_IDLE;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (start_i) phase_q <= PH_SETUP;
                end
                PH_SETUP: phase_q <= PH_ACCESS;
                PH_ACCESS: begin
                    if (pready_i) phase_q <= PH_IDLE; // back to idle between beats
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // address captured once, held through setup and wait states
    always_ff @(posedge clk_i) begin
        if (phase_q == PH_IDLE && start_i) begin
            paddr_o <= addr_i;
        end
    end

    assign psel_o      = (phase_q != PH_IDLE);
    assign penable_o   = (phase_q == PH_ACCESS);
    assign beat_done_o = penable_o & pready_i;  // sample point
    assign beat_err_o  = beat_done_o & pslverr_i;
    assign beat_data_o = prdata_i;

    // requested beat address must not move under a transfer
    a_paddr_stable: assert property (@(posedge clk_i) disable iff (srst_i)
        psel_o |-> paddr_o == addr_i);

endmodule

// File: hw/icache_ctrl_fsm.sv
module icache_ctrl_fsm import icache_pkg::*; (
    input  logic              clk_i,
    input  logic              srst_i,
    input  logic              head_valid_i,
    input  logic [ID_W-1:0]   head_id_i,
    input  logic [ADDR_W-1:0] head_addr_i,
    output logic              pop_o,
    input  logic              hit_i,
    input  logic [DATA_W-1:0] rdata_i,
    input  logic              flush_req_i,
    output logic              flush_ack_o,
    input  logic              beat_done_i,
    input  logic              beat_err_i,
    input  logic              last_beat_i,
    output ctrl_state_e       state_o,
    output logic              refill_busy_o,
    output logic [ADDR_W-1:0] lv2_addr_o,
    output logic              fill_commit_o,
    output logic              flush_clear_o,
    output logic              resp_valid_o,
    output logic [ID_W-1:0]   resp_id_o,
    output logic [DATA_W-1:0] resp_data_o,
    output resp_status_e      resp_status_o
);

    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    logic              lv2_valid;
    logic [ID_W-1:0]   lv2_id;     // level-2 payload
    logic [ADDR_W-1:0] lv2_addr;
    logic              refill_err; // sticky across the beats of one line
    logic              in_run;
    logic              misalign;
    logic              done;       // lv2 can answer this cycle
    logic              miss;
    logic              take_flush;
    logic              line_done;

    assign in_run     = (state_q == ST_RUN);
    assign misalign   = |lv2_addr[1:0];
    assign done       = misalign | refill_err | hit_i; // misalign wins, no refill
    assign miss       = in_run & lv2_valid & ~done;
    assign take_flush = in_run & flush_req_i & ~miss;  // lv2 empty or retiring
    assign pop_o      = in_run & head_valid_i & ~miss & ~take_flush;
    assign line_done  = refill_busy_o & beat_done_i & last_beat_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (miss) begin
                    state_d = ST_REFILL;
                end else if (take_flush) begin
                    state_d = ST_FLUSH;
                end
            end
            ST_REFILL: begin
                if (line_done) state_d = ST_RETRY;
            end
            ST_RETRY: state_d = ST_RUN; // rams re-read at the lv2 address
            default:  state_d = ST_RUN; // flush takes one cycle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (srst_i) begin
            state_q    <= ST_RUN;
            lv2_valid  <= 1'b0;
            refill_err <= 1'b0;
        end else begin
            state_q <= state_d;
            if (pop_o) begin
                lv2_valid <= 1'b1;
            end else if (resp_valid_o) begin
                lv2_valid <= 1'b0;
            end
            if (resp_valid_o) begin
                refill_err <= 1'b0;
            end else if (refill_busy_o & beat_done_i & beat_err_i) begin
                refill_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            lv2_id   <= head_id_i;
            lv2_addr <= head_addr_i;
        end
    end

    always_comb begin
        if (misalign) begin
            resp_status_o = RESP_MISALIGN;
        end else if (refill_err) begin
            resp_status_o = RESP_BUS_ERR;
        end else begin
            resp_status_o = RESP_OK;
        end
    end

    assign resp_valid_o  = in_run & lv2_valid & done;  // strobe, never stalled
    assign resp_id_o     = lv2_id;
    assign resp_data_o   = (resp_status_o == RESP_OK) ? rdata_i : '0;
    assign state_o       = state_q;
    assign refill_busy_o = (state_q == ST_REFILL);
    assign lv2_addr_o    = lv2_addr;
    assign fill_commit_o = line_done & ~refill_err & ~beat_err_i; // clean line only
    assign flush_ack_o   = (state_q == ST_FLUSH);
    assign flush_clear_o = (state_q == ST_FLUSH);

    // outside run level 2 holds the stalled miss, or nothing during a flush
    a_lv2_outside_run: assert property (@(posedge clk_i) disable iff (srst_i)
        !in_run |-> lv2_valid == (state_q != ST_FLUSH));

    // a clean fill must hit on the lookup after the retry cycle
    a_fill_then_hit: assert property (@(posedge clk_i) disable iff (srst_i)
        fill_commit_o |-> ##2 (resp_valid_o && resp_status_o == RESP_OK));

endmodule

// File: hw/icache_top.sv
module icache_top import icache_pkg::*, apb_pkg::*; #(
    parameter int INDEX_W    = 4,   // 16 lines
    parameter int WORD_OFS_W = 2,   // 4 words per line
    localparam int TAG_W     = ADDR_W - INDEX_W - WORD_OFS_W - 2
) (
    input  logic              clk_i,
    input  logic              srst_i,
    input  logic              req_valid_i,
    input  logic [ID_W-1:0]   req_id_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    output logic              req_full_o,
    output logic              resp_valid_o,
    output logic [ID_W-1:0]   resp_id_o,
    output logic [DATA_W-1:0] resp_data_o,
    output resp_status_e      resp_status_o,
    input  logic              flush_req_i,
    output logic              flush_ack_o,
    output logic              psel_o,
    output logic              penable_o,
    output logic [APB_AW-1:0] paddr_o,
    input  logic              pready_i,
    input  logic [APB_DW-1:0] prdata_i,
    input  logic              pslverr_i
);

    localparam int LINE_LSB = WORD_OFS_W + 2;        // lowest index bit
    localparam int RAM_AW   = INDEX_W + WORD_OFS_W;

    logic                  push;
    logic                  pop;
    logic                  fifo_empty;
    logic [ID_W-1:0]       head_id;
    logic [ADDR_W-1:0]     head_addr;
    logic [ADDR_W-1:0]     lv2_addr;
    ctrl_state_e           state;
    logic                  refill_busy;
    logic                  fill_commit;
    logic                  flush_clear;
    logic                  hit;
    logic [DATA_W-1:0]     ram_rdata;
    logic [RAM_AW-1:0]     ram_addr;   // {index, word}
    logic [WORD_OFS_W-1:0] beat_idx;
    logic                  last_beat;
    logic                  beat_done;
    logic                  beat_err;
    logic [APB_DW-1:0]     beat_data;
    logic [APB_AW-1:0]     refill_addr;

    assign push = req_valid_i & ~req_full_o;

    // one ram port, three users
    always_comb begin
        case (state)
            ST_RETRY:  ram_addr = lv2_addr[LINE_LSB+INDEX_W-1:2];
            ST_REFILL: ram_addr = {lv2_addr[LINE_LSB+INDEX_W-1:LINE_LSB], beat_idx};
            default:   ram_addr = head_addr[LINE_LSB+INDEX_W-1:2]; // lookup
        endcase
    end

    assign refill_addr = {lv2_addr[ADDR_W-1:LINE_LSB], beat_idx, 2'b00}; // word beat

    cmd_fifo #(.DEPTH(2)) u_cmd_fifo (
        .clk_i(clk_i), .srst_i(srst_i),
        .push_i(push), .id_i(req_id_i), .addr_i(req_addr_i),
        .pop_i(pop), .id_o(head_id), .addr_o(head_addr),
        .empty_o(fifo_empty), .full_o(req_full_o)
    );

    icache_ctrl_fsm u_ctrl (
        .clk_i(clk_i), .srst_i(srst_i),
        .head_valid_i(~fifo_empty), .head_id_i(head_id), .head_addr_i(head_addr),
        .pop_o(pop), .hit_i(hit), .rdata_i(ram_rdata),
        .flush_req_i(flush_req_i), .flush_ack_o(flush_ack_o),
        .beat_done_i(beat_done), .beat_err_i(beat_err), .last_beat_i(last_beat),
        .state_o(state), .refill_busy_o(refill_busy), .lv2_addr_o(lv2_addr),
        .fill_commit_o(fill_commit), .flush_clear_o(flush_clear),
        .resp_valid_o(resp_valid_o), .resp_id_o(resp_id_o),
        .resp_data_o(resp_data_o), .resp_status_o(resp_status_o)
    );

    tag_store #(.INDEX_W(INDEX_W), .WORD_OFS_W(WORD_OFS_W)) u_tags (
        .clk_i(clk_i), .srst_i(srst_i),
        .rd_index_i(ram_addr[RAM_AW-1:WORD_OFS_W]),
        .lv2_tag_i(lv2_addr[ADDR_W-1 -: TAG_W]), .hit_o(hit),
        .wr_en_i(fill_commit), .wr_index_i(lv2_addr[LINE_LSB +: INDEX_W]),
        .wr_tag_i(lv2_addr[ADDR_W-1 -: TAG_W]), .flush_clear_i(flush_clear)
    );

    data_ram #(.INDEX_W(INDEX_W), .WORD_OFS_W(WORD_OFS_W)) u_data (
        .clk_i(clk_i), .addr_i(ram_addr),
        .we_i(beat_done & ~beat_err),   // errored beats leave the ram alone
        .wdata_i(beat_data), .rdata_o(ram_rdata)
    );

    refill_counter #(.WORD_OFS_W(WORD_OFS_W)) u_beats (
        .clk_i(clk_i), .srst_i(srst_i), .busy_i(refill_busy),
        .beat_done_i(beat_done), .beat_idx_o(beat_idx), .last_beat_o(last_beat)
    );

    apb_refill_master u_apb (
        .clk_i(clk_i), .srst_i(srst_i),
        .start_i(refill_busy), .addr_i(refill_addr),
        .psel_o(psel_o), .penable_o(penable_o), .paddr_o(paddr_o),
        .pready_i(pready_i), .prdata_i(prdata_i), .pslverr_i(pslverr_i),
        .beat_done_o(beat_done), .beat_err_o(beat_err), .beat_data_o(beat_data)
    );

endmodule

// File: bench/apb_mem_model.sv
module apb_mem_model import apb_pkg::*; #(
    parameter int SEED = 1
) (
    input  logic              clk_i,
    input  logic              srst_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,   // held low, reads only
    input  logic [APB_AW-1:0] paddr_i,
    output logic              pready_o,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pslverr_o
);
    timeunit 1ns;
    timeprecision 1ps;

    apb_phase_e phase;
    logic [1:0] wait_q;       // wait states left in this access
    int         seed = SEED;

    assign phase = !psel_i ? PH_IDLE : (penable_i ? PH_ACCESS : PH_SETUP);

    // new random wait count loaded in every setup cycle
    always @(posedge clk_i) begin
        if (srst_i) begin
            wait_q <= 2'd0;
        end else if (phase == PH_SETUP) begin
            wait_q <= 2'($random(seed));
        end else if (phase == PH_ACCESS && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    assign pready_o = (phase == PH_ACCESS) && (wait_q == 2'd0);

    // memory rule, word is its own address scrambled
    assign prdata_o = paddr_i ^ 32'hA5A5_0000;

    // error region at the top of the map, writes are refused too
    assign pslverr_o = pready_o && ((paddr_i >= 32'hF000_0000) || pwrite_i);

endmodule

// File: bench/icache_tb.sv
module icache_tb import icache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_SEED = 41739;
    localparam int TIMEOUT   = 400;   // cycles per wait loop
    localparam int RUN_LIMIT = 20000; // whole run

    logic              clk_i;
    logic              srst_i;
    logic              req_valid_i;
    logic [ID_W-1:0]   req_id_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic              req_full_o;
    logic              resp_valid_o;
    logic [ID_W-1:0]   resp_id_o;
    logic [DATA_W-1:0] resp_data_o;
    resp_status_e      resp_status_o;
    logic              flush_req_i;
    logic              flush_ack_o;
    logic              psel_o;
    logic              penable_o;
    logic [31:0]       paddr_o;
    logic              pready_i;
    logic [31:0]       prdata_i;
    logic              pslverr_i;
    logic              pwrite;

    logic [ID_W+ADDR_W-1:0] pend_q [$];  // {id, addr} of outstanding fetches
    int                q_cnt;
    logic [ID_W-1:0]   exp_id;
    logic [DATA_W-1:0] exp_data;
    resp_status_e      exp_status;
    int                beat_total;
    logic              probe_q;        // marks a fetch whose latency is checked
    logic              no_bus_window;  // psel must stay low
    logic [ID_W-1:0]   next_id;
    int                seed = RAND_SEED;
    int                data_err;
    int                proto_err;
    logic              timed_out;
    logic              seq_done;

    icache_top #(.INDEX_W(4), .WORD_OFS_W(2)) uut (
        .clk_i(clk_i), .srst_i(srst_i),
        .req_valid_i(req_valid_i), .req_id_i(req_id_i), .req_addr_i(req_addr_i),
        .req_full_o(req_full_o),
        .resp_valid_o(resp_valid_o), .resp_id_o(resp_id_o),
        .resp_data_o(resp_data_o), .resp_status_o(resp_status_o),
        .flush_req_i(flush_req_i), .flush_ack_o(flush_ack_o),
        .psel_o(psel_o), .penable_o(penable_o), .paddr_o(paddr_o),
        .pready_i(pready_i), .prdata_i(prdata_i), .pslverr_i(pslverr_i)
    );

    apb_mem_model #(.SEED(RAND_SEED)) u_mem (
        .clk_i(clk_i), .srst_i(srst_i), .psel_i(psel_o), .penable_i(penable_o),
        .pwrite_i(pwrite), .paddr_i(paddr_o),
        .pready_o(pready_i), .prdata_o(prdata_i), .pslverr_o(pslverr_i)
    );

    always #20 clk_i = ~clk_i;

    // expected answer straight from the address rules
    function automatic resp_status_e status_for(input logic [ADDR_W-1:0] addr);
        if (addr[1:0] != 2'b00) begin
            status_for = RESP_MISALIGN;
        end else if (addr >= 32'hF000_0000) begin
            status_for = RESP_BUS_ERR;
        end else begin
            status_for = RESP_OK;
        end
    endfunction

    function automatic logic [DATA_W-1:0] word_for(input logic [ADDR_W-1:0] addr);
        word_for = (status_for(addr) == RESP_OK) ? (addr ^ 32'hA5A5_0000) : '0;
    endfunction

    // reference queue and apb beat count
    always @(posedge clk_i) begin
        if (srst_i) begin
            pend_q.delete();
        end else begin
            if (req_valid_i && !req_full_o) pend_q.push_back({req_id_i, req_addr_i});
            if (resp_valid_o && pend_q.size() > 0) pend_q.pop_front();
            if (psel_o && penable_o && pready_i) beat_total++;
        end
        q_cnt <= pend_q.size();
        if (pend_q.size() > 0) begin
            exp_id     <= pend_q[0][ID_W+ADDR_W-1:ADDR_W];
            exp_data   <= word_for(pend_q[0][ADDR_W-1:0]);
            exp_status <= status_for(pend_q[0][ADDR_W-1:0]);
        end
    end

    a_resp_expected: assert property (@(posedge clk_i) disable iff (srst_i)
        resp_valid_o |-> q_cnt != 0)
        else begin
            $display("response at t=%0t with no fetch outstanding", $time);
            data_err++;
        end
    a_resp_id: assert property (@(posedge clk_i) disable iff (srst_i)
        resp_valid_o && q_cnt != 0 |-> resp_id_o == exp_id)
        else begin
            $display("CHECK FAILED t=%0t resp_id_o expected %h got %h",
                $time, $sampled(exp_id), $sampled(resp_id_o));
            data_err++;
        end
    a_resp_status: assert property (@(posedge clk_i) disable iff (srst_i)
        resp_valid_o && q_cnt != 0 |-> resp_status_o == exp_status)
        else begin
            $display("CHECK FAILED t=%0t resp_status_o expected %0d got %0d",
                $time, $sampled(exp_status), $sampled(resp_status_o));
            data_err++;
        end
    a_resp_data: assert property (@(posedge clk_i) disable iff (srst_i)
        resp_valid_o && q_cnt != 0 |-> resp_data_o == exp_data)
        else begin
            $display("CHECK FAILED t=%0t resp_data_o expected %h got %h",
                $time, $sampled(exp_data), $sampled(resp_data_o));
            data_err++;
        end

    // buffer flag against fetches in flight, level 2 holds at most one
    a_full_at_three: assert property (@(posedge clk_i) disable iff (srst_i)
        q_cnt >= 3 |-> req_full_o)
        else begin
            $display("CHECK FAILED t=%0t req_full_o expected 1 got %b",
                $time, $sampled(req_full_o));
            proto_err++;
        end
    a_full_needs_two: assert property (@(posedge clk_i) disable iff (srst_i)
        req_full_o |-> q_cnt >= 2)
        else begin
            $display("CHECK FAILED t=%0t req_full_o expected 0 got %b",
                $time, $sampled(req_full_o));
            proto_err++;
        end

    // hit into an idle cache, answer on the second edge after acceptance
    a_hit_latency: assert property (@(posedge clk_i) disable iff (srst_i)
        probe_q && req_valid_i && !req_full_o |-> ##1 !resp_valid_o ##1 resp_valid_o)
        else begin
            $display("hit response not 2 cycles after acceptance at t=%0t", $time);
            proto_err++;
        end
    a_quiet_bus: assert property (@(posedge clk_i) disable iff (srst_i)
        no_bus_window |-> !psel_o)
        else begin
            $display("apb transfer started for a misaligned fetch at t=%0t", $time);
            proto_err++;
        end

    a_enable_needs_sel: assert property (@(posedge clk_i) disable iff (srst_i)
        penable_o |-> psel_o)
        else begin
            $display("penable high without psel at t=%0t", $time);
            proto_err++;
        end
    a_setup_first: assert property (@(posedge clk_i) disable iff (srst_i)
        $rose(psel_o) |-> !penable_o)
        else begin
            $display("apb transfer skipped its setup cycle at t=%0t", $time);
            proto_err++;
        end
    a_addr_hold: assert property (@(posedge clk_i) disable iff (srst_i)
        psel_o && !(penable_o && pready_i) |=> psel_o && $stable(paddr_o))
        else begin
            $display("psel or paddr changed before pready at t=%0t", $time);
            proto_err++;
        end
    a_enable_hold: assert property (@(posedge clk_i) disable iff (srst_i)
        penable_o && !pready_i |=> penable_o)
        else begin
            $display("penable dropped during wait states at t=%0t", $time);
            proto_err++;
        end
    a_whole_lines: assert property (@(posedge clk_i) disable iff (srst_i)
        q_cnt == 0 |-> (beat_total % 4) == 0)
        else begin
            $display("refill did not make 4 transfers, %0d beats at t=%0t",
                $sampled(beat_total), $time);
            proto_err++;
        end
    a_ack_asked: assert property (@(posedge clk_i) disable iff (srst_i)
        flush_ack_o |-> flush_req_i)
        else begin
            $display("flush_ack_o without a flush request at t=%0t", $time);
            proto_err++;
        end
    a_ack_pulse: assert property (@(posedge clk_i) disable iff (srst_i)
        flush_ack_o |=> !flush_ack_o)
        else begin
            $display("flush_ack_o longer than one cycle at t=%0t", $time);
            proto_err++;
        end

    // one fetch, waits out back-pressure
    task automatic send_fetch(input logic [ADDR_W-1:0] addr, input logic probe);
        int t;
        t = 0;
        req_valid_i <= 1'b1;
        req_id_i    <= next_id;
        req_addr_i  <= addr;
        probe_q     <= probe;
        @(posedge clk_i);
        while (req_full_o && !timed_out) begin
            t++;
            if (t > TIMEOUT) begin
                $display("timeout: request buffer stayed full at t=%0t", $time);
                timed_out = 1'b1;
            end
            @(posedge clk_i);
        end
        req_valid_i <= 1'b0;
        probe_q     <= 1'b0;
        next_id      = next_id + 4'd1;
    endtask

    // nothing outstanding and the bus at rest
    task automatic wait_idle();
        int t;
        t = 0;
        @(posedge clk_i);
        while ((q_cnt != 0 || psel_o) && !timed_out) begin
            t++;
            if (t > TIMEOUT) begin
                $display("timeout: fetches still outstanding at t=%0t", $time);
                timed_out = 1'b1;
            end
            @(posedge clk_i);
        end
        @(posedge clk_i);
    endtask

    task automatic do_flush();
        int t;
        t = 0;
        flush_req_i <= 1'b1;
        @(posedge clk_i);
        while (!flush_ack_o && !timed_out) begin
            t++;
            if (t > TIMEOUT) begin
                $display("timeout: flush was never acknowledged at t=%0t", $time);
                timed_out = 1'b1;
            end
            @(posedge clk_i);
        end
        flush_req_i <= 1'b0;
    endtask

    task automatic check_beats(input int b0, input int n);
        a_refill_count: assert (beat_total == b0 + n)
            else begin
                $display("CHECK FAILED t=%0t apb beat count expected %0d got %0d",
                    $time, b0 + n, beat_total);
                proto_err++;
            end
    endtask

    initial begin
        int          b0;
        logic [31:0] r;
        logic [31:0] addr;
        clk_i = 1'b0;
        srst_i = 1'b1;
        req_valid_i = 1'b0;
        req_id_i = '0;
        req_addr_i = '0;
        flush_req_i = 1'b0;
        pwrite = 1'b0;
        probe_q = 1'b0;
        no_bus_window = 1'b0;
        next_id = '0;
        beat_total = 0;
        data_err = 0;
        proto_err = 0;
        timed_out = 1'b0;
        seq_done = 1'b0;
        repeat (4) @(posedge clk_i);
        srst_i <= 1'b0;
        @(posedge clk_i);

        b0 = beat_total;          // cold miss then hits on one line
        for (int w = 0; w < 4; w++) send_fetch(32'h0000_1000 + 32'(w * 4), 1'b0);
        wait_idle();
        check_beats(b0, 4);
        send_fetch(32'h0000_1004, 1'b1);  // timed hit
        wait_idle();

        no_bus_window <= 1'b1;
        send_fetch(32'h0000_2002, 1'b0);
        wait_idle();
        no_bus_window <= 1'b0;

        b0 = beat_total;          // error line must stay invalid
        send_fetch(32'hF000_0040, 1'b0);
        wait_idle();
        check_beats(b0, 4);
        send_fetch(32'hF000_0044, 1'b0);
        wait_idle();
        check_beats(b0, 8);

        do_flush();
        b0 = beat_total;
        send_fetch(32'h0000_1008, 1'b0);
        wait_idle();
        check_beats(b0, 4);

        // random bursts across conflicting lines and the error region
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            addr = (r[4] && r[5] ? 32'hF000_0000 : 32'h0000_3000) | (r & 32'h0000_01FC);
            if (r[20] && r[21]) addr[1:0] = r[1:0];
            send_fetch(addr, 1'b0);
            if (r[27:26] == 2'b00) @(posedge clk_i);
        end
        wait_idle();
        seq_done = 1'b1;
    end

    initial begin
        int cyc;
        cyc = 0;
        @(posedge clk_i);
        while (!seq_done && !timed_out) begin
            cyc++;
            if (cyc > RUN_LIMIT) begin
                $display("timeout: test sequence did not finish");
                timed_out = 1'b1;
            end
            @(posedge clk_i);
        end
        $display("errors: data %0d, protocol %0d, timeout %0d",
            data_err, proto_err, timed_out ? 1 : 0);
        if (data_err == 0 && proto_err == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/icache_pkg.sv
hw/apb_pkg.sv
hw/cmd_fifo.sv
hw/tag_store.sv
hw/data_ram.sv
hw/refill_counter.sv
hw/apb_refill_master.sv
hw/icache_ctrl_fsm.sv
hw/icache_top.sv
bench/apb_mem_model.sv
bench/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the icache testbench with verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 -f sources.f --top-module icache_tb \
    > build.log 2>&1 \
    && ./obj_dir/Vicache_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
